//--- source/sdram_pkg.sv
/* sdram controller shared definitions
   geometry, timing constants, command and step encodings, pin and request structs */

package sdram_pkg;

	// ------------------------------
	// geometry and timing
	// ------------------------------
	localparam int data_w = 16;	// sdram word width
	localparam int row_w = 13;	// A12-A0 carry the row
	localparam int col_w = 9;	// 512 columns per row
	localparam int bank_w = 2;	// four banks

	localparam int burst_len = 8;	// words per write burst, must stay at 4 or more
	localparam int read_words = 4;	// read bursts are fixed at four words
	localparam int cas_latency = 2;
	localparam int rascas_delay = 2;	// steps from ACTIVE to READ or WRITE

	// power-up countdown, one count per access cycle
	localparam int init_count = 31;
	localparam int init_precharge_at = 13;
	localparam int init_mode_at = 2;

	// full page burst, sequential, cas latency, burst mode writes, standard operation
	localparam logic [row_w-1:0] mode_word = {3'b000, 1'b0, 2'b00, 3'(cas_latency), 1'b0, 3'b111};

	// ------------------------------
	// cycle steps
	// ------------------------------
	// every step of the 16 step cycle has a name so the counter can walk through the enum
	typedef enum logic [3:0] {
		step_first = 4'd0,	// waits here for clkref low
		step_cmd_start = 4'd1,	// new command starts, ACTIVE or AUTO REFRESH
		step_rcd = 4'd2,
		step_cmd_cont = 4'(1 + rascas_delay),	// READ or WRITE once tRCD has passed
		step_burst = 4'd4,	// held here by freeze during long write bursts
		step_cas1 = 4'd5,
		step_cas2 = 4'd6,
		step_read1 = 4'd7,	// first read word is sampled at the end of this step
		step_read2 = 4'd8,
		step_read3 = 4'd9,	// PRECHARGE closes the row here
		step_read4 = 4'd10,
		step_rd_done = 4'd11,
		step_tail1 = 4'd12,
		step_tail2 = 4'd13,
		step_tail3 = 4'd14,
		step_last = 4'd15	// waits here for clkref high
	} cycle_step_e;

	// command bits in the order cs, ras, cas, we
	typedef enum logic [3:0] {
		cmd_inhibit = 4'b1111,
		cmd_active = 4'b0011,
		cmd_read = 4'b0101,
		cmd_write = 4'b0100,
		cmd_burst_terminate = 4'b0110,
		cmd_precharge = 4'b0010,
		cmd_auto_refresh = 4'b0001,
		cmd_load_mode = 4'b0000
	} sdram_cmd_e;

	// ------------------------------
	// bundles
	// ------------------------------
	typedef struct packed {
		sdram_cmd_e cmd;	// drives cs, ras, cas, we in that order
		logic [bank_w-1:0] bank;
		logic [row_w-1:0] addr;
		logic [1:0] dqm;	// high masks the byte
	} sdram_pins_t;

	typedef struct packed {
		logic we;	// write request, wins over oe
		logic oe;	// read request
		logic [1:0] mask;	// byte mask for all words of a write burst
		logic [bank_w-1:0] bank;
		logic [row_w-1:0] row;
		logic [col_w-1:0] col;	// first column of the burst
	} mem_req_t;

endpackage

//--- source/sdram_cycle_sequencer.sv
/* access cycle sequencer
   16 step counter aligned to clkref, held by freeze during long write bursts */

module sdram_cycle_sequencer (
	input logic fpga_clk,
	input logic rst_n,
	input logic clkref,	// reference clock the cycle lines up with
	input logic freeze,	// holds the step while a write burst runs
	output sdram_pkg::cycle_step_e step
);
	import sdram_pkg::*;

	// the two ends of the cycle wait on clkref so that a cycle passes step_last
	// only right after clkref has risen
	// freeze wins over everything, but it is only ever raised in step_burst

	always_ff @(posedge fpga_clk or negedge rst_n) begin
		if (!rst_n) begin
			step <= step_first;
		end else if (!freeze) begin
			if (step == step_last) begin
				if (clkref)	// leave only once clkref is high
					step <= step_first;
			end else if (step == step_first) begin
				if (!clkref)	// and start the next cycle on its low phase
					step <= step_cmd_start;
			end else begin
				step <= cycle_step_e'(step + 4'd1);	// plain one clock per step
			end
		end
	end

	// the middle steps never wait, so ACTIVE to READ or WRITE spacing is
	// fixed at rascas_delay clocks and the read sample points are fixed too
	// freeze is the only way to stretch the cycle, and that is done in step_burst
	// where the sdram is busy taking write words and needs no new command

endmodule

//--- source/sdram_init_sequencer.sv
/* sdram power-up sequencer
   counts down over access cycles, issues PRECHARGE ALL then LOAD MODE, flags ready */

module sdram_init_sequencer (
	input logic fpga_clk,
	input logic rst_n,
	input sdram_pkg::cycle_step_e step,
	output logic init_busy,	// high until the countdown is done
	output sdram_pkg::sdram_cmd_e init_cmd,
	output logic sdram_ready
);
	import sdram_pkg::*;

	logic [4:0] countdown;	// one count per access cycle
	logic in_last_d;	// step was step_last in the previous clock

	// ------------------------------
	// countdown
	// ------------------------------
	// step_last can last several clocks while waiting on clkref, so only its first clock counts
	always_ff @(posedge fpga_clk or negedge rst_n) begin
		if (!rst_n) begin
			countdown <= 5'(init_count);
			in_last_d <= 1'b0;
			sdram_ready <= 1'b0;
		end else begin
			in_last_d <= (step == step_last);
			if ((step == step_last) && !in_last_d && (countdown != 5'd0))
				countdown <= countdown - 5'd1;
			sdram_ready <= (countdown == 5'd0);	// one clock behind the countdown
		end
	end

	assign init_busy = (countdown != 5'd0);

	// ------------------------------
	// init commands
	// ------------------------------
	// the encoder adds A10 for the precharge and mode_word for the mode load
	always_comb begin
		init_cmd = cmd_inhibit;	// nop for all other counts
		if (step == step_cmd_start) begin
			if (countdown == 5'(init_precharge_at))
				init_cmd = cmd_precharge;	// closes all banks
			else if (countdown == 5'(init_mode_at))
				init_cmd = cmd_load_mode;
		end
	end

endmodule

//--- source/sdram_access_engine.sv
/* access engine
   takes one request per cycle, runs write and read bursts, drives the user strobes */

module sdram_access_engine (
	input logic fpga_clk,
	input logic rst_n,
	input sdram_pkg::cycle_step_e step,
	input logic init_busy,
	input sdram_pkg::mem_req_t req,	// held by the user until cmd_ack
	input logic [sdram_pkg::data_w-1:0] data_from_sdram,
	output sdram_pkg::mem_req_t active_req,	// request of the running cycle
	output logic write_phase,	// write words are on the bus
	output logic burst_end,	// one clock after the last write word
	output logic freeze,
	output logic cmd_ack,
	output logic input_ready,
	output logic output_ready,
	output logic [sdram_pkg::data_w-1:0] dout
);
	import sdram_pkg::*;

	mem_req_t taken;	// request as seen in step_cmd_start
	mem_req_t held_req;	// latched copy for the rest of the cycle
	logic [col_w-1:0] col_cnt;	// word index inside the write burst
	logic rd_capture;	// a read word is on data_from_sdram this clock

	// ------------------------------
	// request intake
	// ------------------------------
	always_comb begin
		taken = req;
		taken.oe = req.oe & ~req.we;	// a write wins over a read
		if (init_busy) begin
			taken.we = 1'b0;	// nothing is taken before the sdram is set up
			taken.oe = 1'b0;
		end
	end

	// the live request is shown in step_cmd_start so ACTIVE goes out in that same step
	assign active_req = (step == step_cmd_start) ? taken : held_req;
	assign cmd_ack = (step == step_cmd_start) && (taken.we || taken.oe);	// idle cycles never ack

	// ------------------------------
	// write burst
	// ------------------------------
	// write_phase opens in step_rcd so it is high in the clock that carries WRITE
	// freeze parks the sequencer in step_burst for burst_len - 3 clocks, which
	// together with steps 3, 4 and 5 gives exactly burst_len words
	always_ff @(posedge fpga_clk or negedge rst_n) begin
		if (!rst_n) begin
			held_req <= '0;
			write_phase <= 1'b0;
			burst_end <= 1'b0;
			freeze <= 1'b0;
			col_cnt <= '0;
		end else begin
			if (step == step_cmd_start)
				held_req <= taken;	// idle cycles latch we and oe low

			burst_end <= write_phase && (col_cnt == col_w'(burst_len - 1));

			if (held_req.we && (step == step_rcd)) begin
				write_phase <= 1'b1;
				col_cnt <= '0;	// word 0 goes with the WRITE command
			end else if (write_phase) begin
				col_cnt <= col_cnt + 1'b1;
				if (col_cnt == col_w'(burst_len - 1))
					write_phase <= 1'b0;	// last word has been sent
			end

			if (write_phase && (step == step_cmd_cont))
				freeze <= 1'b1;	// sequencer stops once it reaches step_burst
			else if (freeze && (col_cnt == col_w'(burst_len - 3)))
				freeze <= 1'b0;
		end
	end

	assign input_ready = write_phase;	// the user hands over din while words are sent

	// ------------------------------
	// read burst
	// ------------------------------
	// word k is sampled at the end of step_read1 + k
	assign rd_capture = held_req.oe && (step >= step_read1) && (step < step_read1 + read_words);

	always_ff @(posedge fpga_clk or negedge rst_n) begin
		if (!rst_n)
			output_ready <= 1'b0;
		else
			output_ready <= rd_capture;	// one clock behind, while dout holds the word
	end

	always_ff @(posedge fpga_clk) begin
		if (rd_capture)
			dout <= data_from_sdram;
	end

endmodule

//--- source/sdram_command_encoder.sv
/* sdram command encoder
   builds command, bank, address and byte mask from the step, the access and the init state */

module sdram_command_encoder (
	input sdram_pkg::cycle_step_e step,
	input logic init_busy,
	input sdram_pkg::sdram_cmd_e init_cmd,
	input sdram_pkg::mem_req_t active_req,
	input logic write_phase,
	input logic burst_end,
	input logic [sdram_pkg::data_w-1:0] din,
	output sdram_pkg::sdram_pins_t sd_pins,
	output logic [sdram_pkg::data_w-1:0] data_to_sdram
);
	import sdram_pkg::*;

	logic is_access;	// the running cycle reads or writes

	assign is_access = active_req.we || active_req.oe;

	// ------------------------------
	// pin mux
	// ------------------------------
	always_comb begin
		sd_pins.cmd = cmd_inhibit;
		sd_pins.bank = '0;
		sd_pins.addr = '0;
		sd_pins.dqm = 2'b00;

		if (init_busy) begin
			sd_pins.cmd = init_cmd;	// mostly inhibit during power-up
			if (init_cmd == cmd_precharge)
				sd_pins.addr[10] = 1'b1;	// A10 high selects all banks
			else if (init_cmd == cmd_load_mode)
				sd_pins.addr = mode_word;
		end else begin
			sd_pins.bank = active_req.bank;
			if (write_phase)
				sd_pins.dqm = active_req.mask;	// same mask for every word of the burst

			if (burst_end) begin
				// stops the full page burst, the row stays open until step_read3
				sd_pins.cmd = cmd_burst_terminate;
			end else begin
				case (step)
					step_cmd_start: begin
						if (is_access) begin
							sd_pins.cmd = cmd_active;
							sd_pins.addr = active_req.row;
						end else begin
							sd_pins.cmd = cmd_auto_refresh;	// all banks are closed here
						end
					end
					step_cmd_cont: begin
						// A10 stays low, no auto precharge on full page bursts
						sd_pins.addr = {{(row_w - col_w){1'b0}}, active_req.col};
						if (active_req.we)
							sd_pins.cmd = cmd_write;
						else if (active_req.oe)
							sd_pins.cmd = cmd_read;
					end
					step_read3: begin
						if (is_access)
							sd_pins.cmd = cmd_precharge;	// closes this bank only
					end
					default: begin
						sd_pins.cmd = cmd_inhibit;
					end
				endcase
			end
		end
	end

	assign data_to_sdram = din;	// the user times din with input_ready

endmodule

//--- source/sdram_controller.sv
/* sdram controller top level
   ties the cycle sequencer, init sequencer, access engine and command encoder together */

module sdram_controller (
	input logic fpga_clk,
	input logic rst_n,
	input logic clkref,
	input sdram_pkg::mem_req_t req,
	input logic [sdram_pkg::data_w-1:0] din,
	input logic [sdram_pkg::data_w-1:0] data_from_sdram,
	output sdram_pkg::sdram_pins_t sd_pins,
	output logic [sdram_pkg::data_w-1:0] data_to_sdram,
	output logic [sdram_pkg::data_w-1:0] dout,
	output logic cmd_ack,
	output logic input_ready,
	output logic output_ready,
	output logic sdram_ready
);
	import sdram_pkg::*;

	cycle_step_e step;
	logic freeze;
	logic init_busy;
	sdram_cmd_e init_cmd;
	mem_req_t active_req;
	logic write_phase;
	logic burst_end;

	// ------------------------------
	// timing
	// ------------------------------
	sdram_cycle_sequencer u_cycle (
		.fpga_clk(fpga_clk),
		.rst_n(rst_n),
		.clkref(clkref),
		.freeze(freeze),
		.step(step)
	);

	sdram_init_sequencer u_init (
		.fpga_clk(fpga_clk),
		.rst_n(rst_n),
		.step(step),
		.init_busy(init_busy),
		.init_cmd(init_cmd),
		.sdram_ready(sdram_ready)
	);

	// ------------------------------
	// access and pins
	// ------------------------------
	sdram_access_engine u_engine (
		.fpga_clk(fpga_clk),
		.rst_n(rst_n),
		.step(step),
		.init_busy(init_busy),
		.req(req),
		.data_from_sdram(data_from_sdram),
		.active_req(active_req),
		.write_phase(write_phase),
		.burst_end(burst_end),
		.freeze(freeze),
		.cmd_ack(cmd_ack),
		.input_ready(input_ready),
		.output_ready(output_ready),
		.dout(dout)
	);

	sdram_command_encoder u_encoder (
		.step(step),
		.init_busy(init_busy),
		.init_cmd(init_cmd),
		.active_req(active_req),
		.write_phase(write_phase),
		.burst_end(burst_end),
		.din(din),
		.sd_pins(sd_pins),
		.data_to_sdram(data_to_sdram)
	);

endmodule

//--- sim/sdram_memory_model.sv
/* behavioral sdram
   stores write bursts, returns read bursts and checks the command rules */

module sdram_memory_model (
	input logic fpga_clk,
	input sdram_pkg::sdram_pins_t sd_pins,
	input logic [sdram_pkg::data_w-1:0] data_to_sdram,
	output logic [sdram_pkg::data_w-1:0] data_from_sdram,
	output logic rule_error	// stays high once any command rule is broken
);
	import sdram_pkg::*;

	logic [data_w-1:0] mem [int];	// sparse storage keyed by bank, row and column
	logic [3:0] bank_open;
	logic [row_w-1:0] open_row [4];
	int act_time [4];	// clock count of the last ACTIVE per bank
	int clk_cnt;
	logic mode_loaded;
	logic wr_on;	// full page write burst running
	int wr_n;
	logic rd_on;
	int rd_edges;	// edges since READ was sampled
	logic [bank_w-1:0] burst_bank;
	logic [col_w-1:0] burst_col;

	function automatic int addr_key(logic [bank_w-1:0] b, logic [row_w-1:0] r,
		logic [col_w-1:0] c);
		return int'({b, r, c});
	endfunction

	task automatic flag(string why);
		$display("memory model: %s at time %0t", why, $time);
		rule_error = 1'b1;
	endtask

	// merges one write word, a high dqm bit keeps the old byte
	task automatic store_word(int i);
		int k;
		logic [data_w-1:0] old;
		k = addr_key(burst_bank, open_row[burst_bank], burst_col + col_w'(i));
		old = mem.exists(k) ? mem[k] : '0;
		if (!sd_pins.dqm[0])
			old[7:0] = data_to_sdram[7:0];
		if (!sd_pins.dqm[1])
			old[15:8] = data_to_sdram[15:8];
		mem[k] = old;
	endtask

	initial begin
		data_from_sdram = '0;
		rule_error = 1'b0;
		bank_open = '0;
		clk_cnt = 0;
		mode_loaded = 1'b0;
		wr_on = 1'b0;
		rd_on = 1'b0;
	end

	always @(posedge fpga_clk) begin
		clk_cnt++;
		// a running write burst takes a word every clock until BURST TERMINATE
		if (wr_on) begin
			if (sd_pins.cmd == cmd_burst_terminate) begin
				if (wr_n != burst_len)
					flag("write burst ended with the wrong number of words");
				wr_on = 1'b0;
			end else begin
				store_word(wr_n);
				wr_n++;
			end
		end
		case (sd_pins.cmd)
			cmd_active: begin
				if (!mode_loaded)
					flag("ACTIVE issued before the mode register was loaded");
				if (bank_open[sd_pins.bank])
					flag("ACTIVE issued to a bank that is already open");
				bank_open[sd_pins.bank] = 1'b1;
				open_row[sd_pins.bank] = sd_pins.addr;
				act_time[sd_pins.bank] = clk_cnt;
			end
			cmd_write, cmd_read: begin
				if (!bank_open[sd_pins.bank])
					flag("READ or WRITE issued to a closed bank");
				else if (clk_cnt - act_time[sd_pins.bank] < rascas_delay)
					flag("READ or WRITE issued too soon after ACTIVE");
				burst_bank = sd_pins.bank;
				burst_col = sd_pins.addr[col_w-1:0];
				if (sd_pins.cmd == cmd_write) begin
					store_word(0);	// word 0 travels with the command
					wr_on = 1'b1;
					wr_n = 1;
				end else begin
					rd_on = 1'b1;
					rd_edges = 0;
				end
			end
			cmd_precharge: begin
				if (sd_pins.addr[10])
					bank_open = '0;	// precharge all
				else
					bank_open[sd_pins.bank] = 1'b0;
			end
			cmd_auto_refresh: begin
				if (bank_open != '0)
					flag("AUTO REFRESH issued while a bank is open");
			end
			cmd_load_mode: mode_loaded = 1'b1;
			default: ;
		endcase
		// read words come out one per clock once the latency has passed
		if (rd_on) begin
			rd_edges++;
			if (rd_edges >= cas_latency + 2)
				data_from_sdram <= mem[addr_key(burst_bank, open_row[burst_bank],
					burst_col + col_w'(rd_edges - cas_latency - 2))];
			if (rd_edges == cas_latency + 1 + read_words)
				rd_on = 1'b0;
		end
	end

endmodule

//--- sim/tb_sdram_controller.sv
/* sdram controller testbench
   random writes, reads and idle gaps against a reference memory, with a command checking model */

module tb_sdram_controller;
	import sdram_pkg::*;

	localparam int num_req = 40;
	localparam int timeout_cycles = num_req * 40 + 400;	// init takes about 500 of these

	logic fpga_clk;
	logic rst_n;
	logic clkref;
	mem_req_t req;
	logic [data_w-1:0] din;
	logic [data_w-1:0] data_from_sdram;
	sdram_pins_t sd_pins;
	logic [data_w-1:0] data_to_sdram;
	logic [data_w-1:0] dout;
	logic cmd_ack;
	logic input_ready;
	logic output_ready;
	logic sdram_ready;
	logic rule_error;

	integer seed;
	logic [2:0] ref_div;	// clkref is fpga_clk divided by eight
	logic [data_w-1:0] ref_mem [int];	// what the sdram should hold
	logic [data_w-1:0] exp_q [$];	// read words still to come out on dout
	logic [23:0] written_q [$];	// start addresses of finished write bursts
	logic [data_w-1:0] wdata [burst_len];
	logic [data_w-1:0] sent_words [burst_len];	// words of the burst now on the bus
	int widx;
	int cycles;
	int ack_count;
	int burst_count;	// write and read bursts seen on the strobes
	int refresh_count;
	int ir_run;
	int or_run;
	logic pre_seen;
	logic load_seen;
	logic ready_d;

	sdram_controller dut (
		.fpga_clk(fpga_clk),
		.rst_n(rst_n),
		.clkref(clkref),
		.req(req),
		.din(din),
		.data_from_sdram(data_from_sdram),
		.sd_pins(sd_pins),
		.data_to_sdram(data_to_sdram),
		.dout(dout),
		.cmd_ack(cmd_ack),
		.input_ready(input_ready),
		.output_ready(output_ready),
		.sdram_ready(sdram_ready)
	);

	sdram_memory_model u_mem (
		.fpga_clk(fpga_clk),
		.sd_pins(sd_pins),
		.data_to_sdram(data_to_sdram),
		.data_from_sdram(data_from_sdram),
		.rule_error(rule_error)
	);

	task automatic abort_run(string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// ------------------------------
	// clocks and timeout
	// ------------------------------
	initial begin
		fpga_clk = 1'b0;
		forever #4 fpga_clk = ~fpga_clk;
	end

	initial begin
		ref_div = '0;
		clkref = 1'b0;
		forever begin
			@(posedge fpga_clk);
			#1;
			ref_div = ref_div + 3'd1;
			clkref = ref_div[2];
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge fpga_clk);
			cycles++;
			if (cycles >= timeout_cycles)
				abort_run("timeout, the controller stopped making progress");
		end
	end

	// write words go out while input_ready is high, one per clock
	initial begin
		forever begin
			@(posedge fpga_clk);
			#1;
			if (input_ready && widx < burst_len) begin
				din = sent_words[widx];
				widx++;
			end
		end
	end

	// ------------------------------
	// monitor, sampled mid-clock
	// ------------------------------
	always @(negedge fpga_clk) begin
		if (rst_n) begin
			assert (!rule_error) else abort_run("memory model saw an illegal command");
			if (!sdram_ready) begin
				if (sd_pins.cmd == cmd_precharge) begin
					assert (sd_pins.addr[10] && !load_seen)
					else abort_run("init precharge without A10 or after LOAD MODE");
					pre_seen = 1'b1;
				end else if (sd_pins.cmd == cmd_load_mode) begin
					assert (pre_seen && sd_pins.addr == mode_word)
					else abort_run("LOAD MODE out of order or with a wrong mode word");
					load_seen = 1'b1;
				end else begin
					assert (sd_pins.cmd == cmd_inhibit)
					else abort_run("unexpected command during initialization");
				end
			end
			if (sdram_ready && !ready_d)
				assert (load_seen) else abort_run("sdram_ready rose before LOAD MODE");
			ready_d = sdram_ready;
			if (sdram_ready && sd_pins.cmd == cmd_auto_refresh)
				refresh_count++;

			if (cmd_ack) begin
				assert (req.we || req.oe) else abort_run("cmd_ack pulsed for an idle request");
				ack_count++;
			end

			// burst lengths are checked when the strobe drops
			if (input_ready) begin
				ir_run++;
			end else if (ir_run != 0) begin
				assert (ir_run == burst_len) else abort_run("input_ready run has a wrong length");
				ir_run = 0;
				burst_count++;
			end
			if (output_ready) begin
				or_run++;
				assert (exp_q.size() > 0) else abort_run("output_ready without a pending read");
				assert (dout === exp_q[0])
				else abort_run($sformatf("MISMATCH at time %0t: dout %h, expected %h",
					$time, dout, exp_q[0]));
				void'(exp_q.pop_front());
			end else if (or_run != 0) begin
				assert (or_run == read_words) else abort_run("output_ready run has a wrong length");
				or_run = 0;
				burst_count++;
			end
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	task automatic wait_ack();
		do
			@(negedge fpga_clk);
		while (!cmd_ack);
		sent_words = wdata;	// the next request may refill wdata while this burst runs
		widx = 0;
		@(posedge fpga_clk);
		#1;
		req = '0;	// may change once the ack is seen
	endtask

	// an idle request must be answered by a refresh cycle
	task automatic idle_gap();
		int start;
		req = '0;
		start = refresh_count;
		while (refresh_count == start)
			@(negedge fpga_clk);
		@(posedge fpga_clk);
		#1;
	endtask

	task automatic issue_write();
		logic [31:0] r;
		logic [col_w-1:0] c;
		logic [data_w-1:0] old;
		int k;
		r = $random(seed);
		req = '0;
		req.we = 1'b1;
		req.bank = r[1:0];
		req.row = r[14:2];
		req.col = r[23:15];
		req.mask = r[25:24];
		for (int i = 0; i < burst_len; i++) begin
			wdata[i] = $random(seed);
			c = req.col + col_w'(i);
			k = int'({req.bank, req.row, c});
			old = ref_mem.exists(k) ? ref_mem[k] : '0;
			if (!req.mask[0])
				old[7:0] = wdata[i][7:0];
			if (!req.mask[1])
				old[15:8] = wdata[i][15:8];
			ref_mem[k] = old;
		end
		written_q.push_back({req.bank, req.row, req.col});
		wait_ack();
	endtask

	task automatic issue_read();
		logic [31:0] r;
		logic [23:0] loc;
		logic [col_w-1:0] c;
		r = $random(seed);
		loc = written_q[r % written_q.size()];
		req = '0;
		req.oe = 1'b1;
		req.bank = loc[23:22];
		req.row = loc[21:9];
		req.col = loc[8:0];
		for (int k = 0; k < read_words; k++) begin
			c = req.col + col_w'(k);
			exp_q.push_back(ref_mem[int'({req.bank, req.row, c})]);
		end
		wait_ack();
	endtask

	initial begin
		logic [31:0] kind;
		seed = 32'he8c6_9505;
		rst_n = 1'b0;
		req = '0;
		din = '0;
		widx = burst_len;
		ack_count = 0;
		burst_count = 0;
		refresh_count = 0;
		ir_run = 0;
		or_run = 0;
		pre_seen = 1'b0;
		load_seen = 1'b0;
		ready_d = 1'b0;
		repeat (8) @(posedge fpga_clk);
		#1;
		rst_n = 1'b1;

		while (!sdram_ready)
			@(negedge fpga_clk);
		@(posedge fpga_clk);
		#1;
		for (int n = 0; n < num_req; n++) begin
			kind = $random(seed);
			if (kind[1:0] == 2'd0)
				idle_gap();
			else if (kind[1:0] == 2'd1 && written_q.size() > 0)
				issue_read();
			else
				issue_write();
		end
		idle_gap();	// the last access cycle has drained once a refresh follows

		if (exp_q.size() == 0 && burst_count == ack_count) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			abort_run("reads left pending or burst count differs from cmd_ack count");
		end
	end

endmodule

//--- build.f
source/sdram_pkg.sv
source/sdram_cycle_sequencer.sv
source/sdram_init_sequencer.sv
source/sdram_access_engine.sv
source/sdram_command_encoder.sv
source/sdram_controller.sv
sim/sdram_memory_model.sv
sim/tb_sdram_controller.sv

//--- run_sim.sh
#!/bin/sh
# builds the sdram controller testbench with Verilator and runs it
# the exit status is the simulator's, so a failed check gives a non-zero status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f build.f \
	--top-module tb_sdram_controller \
	-o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished cleanly"
exit 0
